// ==== flist.f ====
+incdir+.
kmac_cfg_pkg.sv
kmac_ctrl_pkg.sv
kmac_key_if.sv
kmac_key_encoder.sv
kmac_key_streamer.sv
kmac_ctrl.sv
kmac_core.sv
tb_kmac_core.sv

// ==== tb_kmac_core.sv ====
/*
 * KMAC key-prefix core testbench
 * Checks passthrough, the encoded key block for every length and strength,
 * process gating, flush and escalation against a reference model
 */

`timescale 1ns/1ps

`include "kmac_params.svh"

module tb_kmac_core;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  // 25 key runs, passthrough, escalation and two runs after reset
  localparam int NUM_TESTS  = 29;
  // Generous bound for one run including random ready stalls
  localparam int TEST_CYCLES = 300;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         fifo_valid_i;
  logic [`KMAC_MSG_W-1:0]       fifo_data_i;
  logic [`KMAC_STRB_W-1:0]      fifo_strb_i;
  logic                         fifo_ready_o;
  logic                         msg_valid_o;
  logic [`KMAC_MSG_W-1:0]       msg_data_o;
  logic [`KMAC_STRB_W-1:0]      msg_strb_o;
  logic                         msg_ready_i;
  logic                         kmac_en_i;
  kmac_cfg_pkg::strength_e      strength_i;
  kmac_cfg_pkg::key_len_e       key_len_i;
  logic [`KMAC_MAX_KEY_LEN-1:0] key_data_i;
  logic                         start_i;
  logic                         process_i;
  logic                         done_i;
  logic                         process_o;
  logic                         escalate_i;
  logic                         error_o;

  integer seed = 32'h449b_4b6b;

  // Shared between stimulus and checker
  logic [`KMAC_MAX_KEY_LEN-1:0] cur_key;
  int cur_key_bits;
  int cur_rate;
  int cur_limit;
  bit cur_early;
  bit key_phase;
  bit key_done;
  bit err_expected;
  int words_seen;
  // Idle cycles between the last key word and the first StMsg cycle
  int gap_cycles;
  int proc_count;
  int err_count;
  int cycle_count;
  int word_count;

  kmac_core u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Rate in bytes per strength select
  function automatic int rate_of(input int s);
    case (s)
      0:       return 168;
      1:       return 144;
      2:       return 136;
      3:       return 104;
      default: return 72;
    endcase
  endfunction

  function automatic int key_bits_of(input int k);
    case (k)
      0:       return 128;
      1:       return 192;
      2:       return 256;
      3:       return 384;
      default: return 512;
    endcase
  endfunction

  // One 64-bit word of bytepad(encode_string(K), rate) with byte 0 lowest
  function automatic logic [63:0] expected_key_word(input logic [511:0] key,
                                                    input int key_bits,
                                                    input int rate, input int idx);
    logic [7:0]  blk [0:167];
    logic [63:0] word;
    int          pos;
    int          b;
    for (b = 0; b < 168; b++) begin
      blk[b] = 8'h00;
    end
    blk[0] = 8'h01;
    blk[1] = rate[7:0];
    // Key length as left_encode in big-endian order
    if (key_bits < 256) begin
      blk[2] = 8'h01;
      blk[3] = key_bits[7:0];
      pos    = 4;
    end else begin
      blk[2] = 8'h02;
      blk[3] = key_bits[15:8];
      blk[4] = key_bits[7:0];
      pos    = 5;
    end
    for (b = 0; b < key_bits / 8; b++) begin
      blk[pos + b] = key[8 * b +: 8];
    end
    for (b = 0; b < 8; b++) begin
      word[8 * b +: 8] = blk[8 * idx + b];
    end
    return word;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] got_val);
    err_count++;
    $display("mismatch time=%0t %s expected=%h got=%h", $time, name, exp_val, got_val);
  endtask

  task automatic report_failure(input string what);
    err_count++;
    $display("error at time=%0t: %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////
  // Checker sampling mid-cycle where all signals are settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    logic [63:0] exp_word;
    if (rst_ni) begin
      cycle_count++;
      if (kmac_en_i && process_o) begin
        proc_count++;
      end
      assert (error_o == err_expected) else begin
        if (err_expected) report_failure("error_o not raised after escalation");
        else report_failure("error_o raised without escalation");
      end
      if (!kmac_en_i) begin
        assert (process_o == process_i) else report_mismatch("process_o", process_i, process_o);
      end
      if (key_phase) begin
        if (fifo_ready_o) begin
          // First StMsg cycle closes the key phase
          assert (words_seen == cur_limit) else report_failure("FIFO released too early");
          assert (gap_cycles == 1)
            else report_failure("key phase did not end one cycle after the last word");
          assert (process_o == cur_early) else report_mismatch("process_o", cur_early, process_o);
          key_phase = 1'b0;
          key_done  = 1'b1;
        end else begin
          assert (!process_o) else report_failure("process_o raised during the key phase");
          if (msg_valid_o) begin
            assert (words_seen < cur_limit)
              else report_failure("key word past the block limit");
            assert (msg_strb_o == '1) else report_mismatch("msg_strb_o", 64'hff, msg_strb_o);
            if (msg_ready_i && words_seen < cur_limit) begin
              exp_word = expected_key_word(cur_key, cur_key_bits, cur_rate, words_seen);
              assert (msg_data_o == exp_word)
                else report_mismatch("msg_data_o", exp_word, msg_data_o);
              words_seen++;
              word_count++;
            end
          end else if (words_seen == cur_limit) begin
            gap_cycles++;
          end
        end
      end else begin
        // Outside the key phase the FIFO path is a plain wire
        assert (msg_valid_o == fifo_valid_i)
          else report_mismatch("msg_valid_o", fifo_valid_i, msg_valid_o);
        assert (msg_data_o == fifo_data_i)
          else report_mismatch("msg_data_o", fifo_data_i, msg_data_o);
        assert (msg_strb_o == fifo_strb_i)
          else report_mismatch("msg_strb_o", fifo_strb_i, msg_strb_o);
        assert (fifo_ready_o == msg_ready_i)
          else report_mismatch("fifo_ready_o", msg_ready_i, fifo_ready_o);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers returning just after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic step_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic drive_fifo_random();
    fifo_valid_i = $random(seed);
    fifo_data_i  = {$random(seed), $random(seed)};
    fifo_strb_i  = $random(seed);
    msg_ready_i  = ($random(seed) & 3) != 0;
  endtask

  task automatic load_config(input int k, input int s);
    int i;
    for (i = 0; i < 16; i++) begin
      cur_key[32 * i +: 32] = $random(seed);
    end
    cur_key_bits = key_bits_of(k);
    cur_rate     = rate_of(s);
    cur_limit    = cur_rate / 8;
    key_len_i    = kmac_cfg_pkg::key_len_e'(k[2:0]);
    strength_i   = kmac_cfg_pkg::strength_e'(s[2:0]);
    key_data_i   = cur_key;
  endtask

  task automatic apply_reset();
    rst_ni       = 1'b0;
    err_expected = 1'b0;
    repeat (4) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;
  endtask

  // Start and stream the key block under random stalls
  task automatic run_key_phase(input int k, input int s, input bit early);
    int cyc;
    load_config(k, s);
    cur_early = early;
    kmac_en_i = 1'b1;
    start_i   = 1'b1;
    step_cycle();
    start_i    = 1'b0;
    words_seen = 0;
    gap_cycles = 0;
    key_done   = 1'b0;
    key_phase  = 1'b1;
    cyc        = 0;
    while (!key_done) begin
      drive_fifo_random();
      // Stop stalling once the block is out so StMsg shows up at once
      if (words_seen >= cur_limit) begin
        msg_ready_i = 1'b1;
      end
      process_i = early && (cyc == 3);
      cyc++;
      step_cycle();
    end
    process_i = 1'b0;
  endtask

  // Key phase and message forwarding followed by one process pulse and done
  task automatic run_kmac(input int k, input int s, input bit early);
    int i;
    proc_count = 0;
    run_key_phase(k, s, early);
    for (i = 0; i < 4; i++) begin
      drive_fifo_random();
      step_cycle();
    end
    if (!early) begin
      process_i = 1'b1;
      step_cycle();
      process_i = 1'b0;
    end
    fifo_valid_i = 1'b0;
    repeat (2) step_cycle();
    assert (proc_count == 1) else report_failure("expected exactly one process_o pulse");
    done_i = 1'b1;
    step_cycle();
    done_i = 1'b0;
    step_cycle();
  endtask

  task automatic run_passthrough(input int n);
    int i;
    kmac_en_i = 1'b0;
    for (i = 0; i < n; i++) begin
      drive_fifo_random();
      process_i = $random(seed);
      step_cycle();
    end
    process_i = 1'b0;
  endtask

  // Escalate in the middle of a key phase and poke start afterwards
  task automatic run_escalation();
    int i;
    load_config($unsigned($random(seed)) % 5, $unsigned($random(seed)) % 5);
    cur_early = 1'b0;
    kmac_en_i = 1'b1;
    start_i   = 1'b1;
    step_cycle();
    start_i      = 1'b0;
    words_seen   = 0;
    key_done     = 1'b0;
    key_phase    = 1'b1;
    msg_ready_i  = 1'b1;
    fifo_valid_i = 1'b0;
    repeat (3) step_cycle();
    escalate_i = 1'b1;
    step_cycle();
    escalate_i   = 1'b0;
    key_phase    = 1'b0;
    err_expected = 1'b1;
    for (i = 0; i < 8; i++) begin
      drive_fifo_random();
      start_i = $random(seed);
      step_cycle();
    end
    start_i = 1'b0;
    apply_reset();
    step_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int k;
    int s;
    rst_ni       = 1'b0;
    fifo_valid_i = 1'b0;
    fifo_data_i  = '0;
    fifo_strb_i  = '0;
    msg_ready_i  = 1'b0;
    kmac_en_i    = 1'b0;
    strength_i   = kmac_cfg_pkg::L128;
    key_len_i    = kmac_cfg_pkg::Key128;
    key_data_i   = '0;
    start_i      = 1'b0;
    process_i    = 1'b0;
    done_i       = 1'b0;
    escalate_i   = 1'b0;
    key_phase    = 1'b0;
    key_done     = 1'b0;
    err_expected = 1'b0;
    cur_early    = 1'b0;
    words_seen   = 0;
    gap_cycles   = 0;
    proc_count   = 0;
    err_count    = 0;
    cycle_count  = 0;
    word_count   = 0;
    repeat (4) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    step_cycle();

    run_passthrough(10);
    // Every pair with process_i raised early in some runs
    for (k = 0; k < 5; k++) begin
      for (s = 0; s < 5; s++) begin
        run_kmac(k, s, ((5 * k + s) % 3) == 1);
      end
    end
    run_escalation();
    run_kmac($unsigned($random(seed)) % 5, $unsigned($random(seed)) % 5, 1'b0);
    run_kmac($unsigned($random(seed)) % 5, $unsigned($random(seed)) % 5, 1'b1);
    repeat (2) step_cycle();

    $display("cycles=%0d key_words=%0d errors=%0d", cycle_count, word_count, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display("cycles=%0d key_words=%0d errors=%0d", cycle_count, word_count, err_count + 1);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== kmac_core.sv ====
/*
 * KMAC key-prefix core
 * Sits between the message FIFO and SHA3, prepends the encoded key block
 */

`timescale 1ns/1ps

`include "kmac_params.svh"

module kmac_core (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Message FIFO
  input  logic                         fifo_valid_i,
  input  logic [`KMAC_MSG_W-1:0]       fifo_data_i,
  input  logic [`KMAC_STRB_W-1:0]      fifo_strb_i,
  output logic                         fifo_ready_o,
  // SHA3 engine
  output logic                         msg_valid_o,
  output logic [`KMAC_MSG_W-1:0]       msg_data_o,
  output logic [`KMAC_STRB_W-1:0]      msg_strb_o,
  input  logic                         msg_ready_i,
  // Configuration
  input  logic                         kmac_en_i,
  input  kmac_cfg_pkg::strength_e      strength_i,
  input  kmac_cfg_pkg::key_len_e       key_len_i,
  input  logic [`KMAC_MAX_KEY_LEN-1:0] key_data_i,
  // Control
  input  logic                         start_i,
  input  logic                         process_i,
  input  logic                         done_i,
  output logic                         process_o,
  input  logic                         escalate_i,
  output logic                         error_o
);

  // Encoded key block, controller to streamer handshake
  logic [`KMAC_ENC_BLOCK_W-1:0] key_block;
  kmac_key_if                   u_key_if ();

  kmac_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .key_if     (u_key_if.ctrl),
    .kmac_en_i  (kmac_en_i),
    .start_i    (start_i),
    .process_i  (process_i),
    .done_i     (done_i),
    .escalate_i (escalate_i),
    .process_o  (process_o),
    .error_o    (error_o)
  );

  kmac_key_encoder u_encoder (
    .key_data_i (key_data_i),
    .key_len_i  (key_len_i),
    .strength_i (strength_i),
    .block_o    (key_block)
  );

  kmac_key_streamer u_streamer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .key_if       (u_key_if.stream),
    .strength_i   (strength_i),
    .block_i      (key_block),
    .fifo_valid_i (fifo_valid_i),
    .fifo_data_i  (fifo_data_i),
    .fifo_strb_i  (fifo_strb_i),
    .fifo_ready_o (fifo_ready_o),
    .msg_valid_o  (msg_valid_o),
    .msg_data_o   (msg_data_o),
    .msg_strb_o   (msg_strb_o),
    .msg_ready_i  (msg_ready_i)
  );

endmodule

// ==== kmac_ctrl.sv ====
/*
 * KMAC key-prefix controller
 * Sequences the key phase, gates process towards SHA3, traps on escalation
 */

`timescale 1ns/1ps

module kmac_ctrl (
  input  logic     clk_i,
  input  logic     rst_ni,
  kmac_key_if.ctrl key_if,
  input  logic     kmac_en_i,
  input  logic     start_i,
  input  logic     process_i,
  input  logic     done_i,
  input  logic     escalate_i,
  output logic     process_o,
  output logic     error_o
);

  kmac_ctrl_pkg::kmac_st_e st_q, st_d;

  // Key phase level, valid and index clear derive from it
  logic key_write;
  // Process request issued by the FSM in StMsg
  logic kmac_process;
  // Process seen before the FSM could forward it
  logic process_latched;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= kmac_ctrl_pkg::StIdle;
    end else begin
      st_q <= st_d;
    end
  end

  always_comb begin
    st_d         = st_q;
    key_write    = 1'b0;
    kmac_process = 1'b0;

    case (st_q)
      kmac_ctrl_pkg::StIdle: begin
        if (kmac_en_i && start_i) begin
          st_d = kmac_ctrl_pkg::StKey;
        end
      end

      // Full block goes out regardless of process_i
      kmac_ctrl_pkg::StKey: begin
        key_write = 1'b1;
        if (key_if.block_sent) begin
          st_d = kmac_ctrl_pkg::StMsg;
        end
      end

      // Forward a fresh or a latched process
      kmac_ctrl_pkg::StMsg: begin
        if (process_i || process_latched) begin
          kmac_process = 1'b1;
          st_d         = kmac_ctrl_pkg::StFlush;
        end
      end

      kmac_ctrl_pkg::StFlush: begin
        if (done_i) begin
          st_d = kmac_ctrl_pkg::StIdle;
        end
      end

      // Terminal
      kmac_ctrl_pkg::StError: st_d = kmac_ctrl_pkg::StError;

      default: st_d = kmac_ctrl_pkg::StError;
    endcase

    // Escalation wins from any state
    if (escalate_i) begin
      st_d = kmac_ctrl_pkg::StError;
    end
  end

  // Key valid drops in the cycle the limit is hit, then the index clears
  assign key_if.key_write = key_write;
  assign key_if.key_valid = key_write & ~key_if.block_sent;
  assign key_if.clr_index = key_write & key_if.block_sent;

  ////////////////////////////////////////////////////////////
  // Process gating
  ////////////////////////////////////////////////////////////

  // Without KMAC the SHA3 engine sees process_i directly
  assign process_o = kmac_en_i ? kmac_process : process_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_latched <= 1'b0;
    end else if (process_i && !process_o) begin
      process_latched <= 1'b1;
    end else if (process_o || done_i) begin
      process_latched <= 1'b0;
    end
  end

  assign error_o = (st_q == kmac_ctrl_pkg::StError);

endmodule

// ==== kmac_key_streamer.sv ====
/*
 * KMAC key word streamer
 * Slices the encoded key block into message words and muxes the SHA3 path
 */

`timescale 1ns/1ps

`include "kmac_params.svh"

module kmac_key_streamer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  kmac_key_if.stream                   key_if,
  input  kmac_cfg_pkg::strength_e      strength_i,
  input  logic [`KMAC_ENC_BLOCK_W-1:0] block_i,
  // Message FIFO side
  input  logic                         fifo_valid_i,
  input  logic [`KMAC_MSG_W-1:0]       fifo_data_i,
  input  logic [`KMAC_STRB_W-1:0]      fifo_strb_i,
  output logic                         fifo_ready_o,
  // SHA3 side
  output logic                         msg_valid_o,
  output logic [`KMAC_MSG_W-1:0]       msg_data_o,
  output logic [`KMAC_STRB_W-1:0]      msg_strb_o,
  input  logic                         msg_ready_i
);

  // Block zero extended to every index value
  localparam int unsigned ExtW = (2 ** `KMAC_IDX_W) * `KMAC_MSG_W;

  ////////////////////////////////////////////////////////////
  // Word index and block limit
  ////////////////////////////////////////////////////////////

  logic [`KMAC_IDX_W-1:0] key_index;
  logic [`KMAC_IDX_W-1:0] block_limit;

  // Advance only on an accepted key word so stalls hold the word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_index <= '0;
    end else if (key_if.clr_index) begin
      key_index <= '0;
    end else if (key_if.key_valid && msg_ready_i) begin
      key_index <= key_index + 1'b1;
    end
  end

  // Rate in 64-bit words, 21 down to 9
  assign block_limit = `KMAC_IDX_W'(kmac_cfg_pkg::rate_bytes(strength_i) >> 3);

  assign key_if.block_sent = (key_index == block_limit);

  ////////////////////////////////////////////////////////////
  // Slicing and message mux
  ////////////////////////////////////////////////////////////

  logic [ExtW-1:0]        block_ext;
  logic [`KMAC_MSG_W-1:0] key_word;

  // Words past the 552-bit block read as zero padding
  assign block_ext = ExtW'(block_i);
  assign key_word  = block_ext[key_index * `KMAC_MSG_W +: `KMAC_MSG_W];

  // Key phase owns the SHA3 path and stalls the FIFO
  assign msg_valid_o  = key_if.key_write ? key_if.key_valid : fifo_valid_i;
  assign msg_data_o   = key_if.key_write ? key_word : fifo_data_i;
  // Key words are always full width
  assign msg_strb_o   = key_if.key_write ? '1 : fifo_strb_i;
  assign fifo_ready_o = key_if.key_write ? 1'b0 : msg_ready_i;

endmodule

// ==== kmac_key_encoder.sv ====
/*
 * KMAC key block encoder
 * Builds bytepad(encode_string(K), rate) as a little-endian byte vector
 */

`timescale 1ns/1ps

`include "kmac_params.svh"

module kmac_key_encoder (
  input  logic [`KMAC_MAX_KEY_LEN-1:0] key_data_i,
  input  kmac_cfg_pkg::key_len_e       key_len_i,
  input  kmac_cfg_pkg::strength_e      strength_i,
  output logic [`KMAC_ENC_BLOCK_W-1:0] block_o
);

  // encode_string(K) part above the bytepad prefix
  localparam int unsigned EncStrW = `KMAC_ENC_BLOCK_W - 16;

  ////////////////////////////////////////////////////////////
  // Prefix and key length encoding
  ////////////////////////////////////////////////////////////

  // left_encode(rate) with 0x01 in byte 0 and the rate in bytes in byte 1
  logic [15:0] prefix;
  assign prefix = {kmac_cfg_pkg::rate_bytes(strength_i), 8'h01};

  // left_encode(len(K)) already byte swapped for little-endian order
  logic [23:0] len_enc;
  // Key size in bits driving the key mask
  logic [9:0]  key_bits;
  // 128 and 192 need only one length byte
  logic        len_short;

  always_comb begin
    len_enc   = '0;
    key_bits  = '0;
    len_short = 1'b0;
    case (key_len_i)
      kmac_cfg_pkg::Key128: begin
        len_enc   = 24'h00_80_01;
        key_bits  = 10'd128;
        len_short = 1'b1;
      end
      kmac_cfg_pkg::Key192: begin
        len_enc   = 24'h00_c0_01;
        key_bits  = 10'd192;
        len_short = 1'b1;
      end
      kmac_cfg_pkg::Key256: begin
        len_enc  = 24'h00_01_02;
        key_bits = 10'd256;
      end
      kmac_cfg_pkg::Key384: begin
        len_enc  = 24'h80_01_02;
        key_bits = 10'd384;
      end
      kmac_cfg_pkg::Key512: begin
        len_enc  = 24'h00_02_02;
        key_bits = 10'd512;
      end
      default: begin
        len_enc  = '0;
        key_bits = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Key masking and concatenation
  ////////////////////////////////////////////////////////////

  // Only the low key_bits of the CSR key are part of the string
  logic [`KMAC_MAX_KEY_LEN-1:0] key_mask;
  logic [`KMAC_MAX_KEY_LEN-1:0] key_masked;

  // Shift of 512 leaves zero so Key512 keeps the full key
  assign key_mask   = ~({`KMAC_MAX_KEY_LEN{1'b1}} << key_bits);
  assign key_masked = key_data_i & key_mask;

  // Short length encoding pulls the key down one byte and zero fills the top
  logic [EncStrW-1:0] enc_string;
  assign enc_string = len_short ? EncStrW'({key_masked, len_enc[15:0]})
                                : EncStrW'({key_masked, len_enc});

  // Prefix lands in bytes 0 and 1 of word 0
  assign block_o = {enc_string, prefix};

endmodule

// ==== kmac_key_if.sv ====
/*
 * KMAC key phase handshake
 * Links the controller FSM with the key word streamer
 */

`timescale 1ns/1ps

interface kmac_key_if;

  // Level, high for the whole key phase
  logic key_write;
  // Key word valid towards SHA3, low once the block is out
  logic key_valid;
  // Single-cycle pulse at the end of the key phase
  logic clr_index;
  // Word index reached the block limit
  logic block_sent;

  // Controller side
  modport ctrl (
    output key_write,
    output key_valid,
    output clr_index,
    input  block_sent
  );

  // Streamer side
  modport stream (
    input  key_write,
    input  key_valid,
    input  clr_index,
    output block_sent
  );

endinterface

// ==== kmac_ctrl_pkg.sv ====
/*
 * KMAC controller types
 * State encoding of the key-prefix FSM
 */

package kmac_ctrl_pkg;

  // Controller state
  typedef enum logic [2:0] {
    // Waiting for start with KMAC enabled
    StIdle  = 3'd0,
    // Pushing the encoded key block to SHA3
    StKey   = 3'd1,
    // Forwarding FIFO message, waiting for process
    StMsg   = 3'd2,
    // Process sent, waiting for done
    StFlush = 3'd3,
    // Terminal, only left through reset
    StError = 3'd4
  } kmac_st_e;

endpackage

// ==== kmac_cfg_pkg.sv ====
/*
 * KMAC configuration types
 * Key length and Keccak strength selects plus the rate lookup
 */

package kmac_cfg_pkg;

  // Secret key length select
  typedef enum logic [2:0] {
    Key128 = 3'd0,
    Key192 = 3'd1,
    Key256 = 3'd2,
    Key384 = 3'd3,
    Key512 = 3'd4
  } key_len_e;

  // Keccak strength select, sets the sponge rate
  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } strength_e;

  // Sponge rate in bytes for each strength
  // Used both as the bytepad width and, divided by 8, as the block word count
  function automatic logic [7:0] rate_bytes(strength_e strength);
    case (strength)
      L128:    return 8'd168;
      L224:    return 8'd144;
      L256:    return 8'd136;
      L384:    return 8'd104;
      L512:    return 8'd72;
      default: return 8'd0;
    endcase
  endfunction

endpackage

// ==== kmac_params.svh ====
/*
 * KMAC key-prefix stage shared widths and counts
 * Message word, strobe, key and encoded key block sizes
 */

`ifndef KMAC_PARAMS_SVH
`define KMAC_PARAMS_SVH

// Message path word width towards the SHA3 engine
`define KMAC_MSG_W 64

// One strobe bit per message byte
`define KMAC_STRB_W 8

// Widest supported secret key in bits
`define KMAC_MAX_KEY_LEN 512

// bytepad prefix (16) + left_encode(len) (24) + key bits (512)
`define KMAC_ENC_BLOCK_W 552

// Key word index, covers the 21-word L128 block
`define KMAC_IDX_W 5

`endif
